// File: src/dz_pkg.sv
package dz_pkg;

    // scan timing
    localparam int SCAN_DIV = 8;                 // clk cycles per row step
    localparam int SCAN_CNT_W = $clog2(SCAN_DIV);

    // panel geometry
    localparam int ROWS = 8;
    localparam int COLS = 8;
    localparam int ROW_W = 3;
    localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(ROWS - 1);

    // blink schedule, visible phase then blank phase
    localparam int BLINK_FRAMES = 2;
    localparam int BLINK_CNT_W = $clog2(2 * BLINK_FRAMES);

    // glyph numbers
    localparam int GLYPH_W = 3;
    localparam logic [GLYPH_W-1:0] GLYPH_BLANK = 3'd0;
    localparam logic [GLYPH_W-1:0] GLYPH_L1 = 3'd1;   // red only
    localparam logic [GLYPH_W-1:0] GLYPH_L2 = 3'd2;
    localparam logic [GLYPH_W-1:0] GLYPH_L3 = 3'd3;
    localparam logic [GLYPH_W-1:0] GLYPH_L4 = 3'd4;

endpackage

// File: src/dz_scan_if.sv
`timescale 1ns/10ps

interface dz_scan_if
    import dz_pkg::*;
();

    logic               tick;          // one clk wide scan strobe
    logic [ROW_W-1:0]   row_idx;
    logic               frame_start;   // tick that wraps row_idx to 0
    logic [GLYPH_W-1:0] glyph;         // frame-latched glyph number
    logic               blank;

    modport scanner (
        input  tick,
        output row_idx,
        output frame_start
    );

    modport control (
        input  tick,
        input  frame_start,
        output glyph,
        output blank
    );

    modport store (
        input  row_idx,
        input  glyph,
        input  blank
    );

endinterface

// File: src/scan_tick_gen.sv
`timescale 1ns/10ps

module scan_tick_gen
    import dz_pkg::*;
(
    input  logic clk,
    input  logic rst,
    output logic tick
);

    logic [SCAN_CNT_W-1:0] div_cnt;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end
        else if (div_cnt == SCAN_CNT_W'(SCAN_DIV - 1))
        begin
            div_cnt <= '0;
            tick    <= 1'b1;   // first one SCAN_DIV cycles out of reset
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

    // strobe must never stretch, row scan counts every high cycle
    a_tick_single: assert property (
        @(posedge clk) disable iff (rst) tick |=> !tick
    ) else $error("scan tick high on two cycles in a row");

endmodule

// File: src/dz_row_scan.sv
`timescale 1ns/10ps

module dz_row_scan
    import dz_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    dz_scan_if.scanner      scan,
    output logic [ROWS-1:0] row
);

    logic started;   // set by the first tick

    assign scan.frame_start = scan.tick && (scan.row_idx == LAST_ROW);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan.row_idx <= LAST_ROW;   // first tick lands on row 0
            started      <= 1'b0;
        end
        else if (scan.tick)
        begin
            started <= 1'b1;
            if (scan.frame_start)
                scan.row_idx <= '0;
            else
                scan.row_idx <= scan.row_idx + 1'b1;
        end
    end

    // active-low row select, lags row_idx by one clk like the column bytes
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row <= '1;
        else if (started)
            row <= ~(ROWS'(1) << scan.row_idx);
    end

    a_row_onehot: assert property (
        @(posedge clk) disable iff (rst) started |=> $onehot(~row)
    ) else $error("row lines not one-hot active low: %b", row);

endmodule

// File: src/dz_glyph_rom.sv
`timescale 1ns/10ps

module dz_glyph_rom
    import dz_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    dz_scan_if.store        scan,
    output logic [COLS-1:0] colr,
    output logic [COLS-1:0] colg
);

    logic [COLS-1:0] outer_pat;   // rows 1 and 4
    logic [COLS-1:0] inner_pat;   // rows 2 and 3
    logic            red_only;
    logic [COLS-1:0] shape;

    // per-glyph row shapes
    always_comb
    begin
        outer_pat = '0;
        inner_pat = '0;
        red_only  = 1'b0;
        case (scan.glyph)
            GLYPH_L4:
            begin
                outer_pat = 8'h18;
                inner_pat = 8'h3c;
            end
            GLYPH_L3:
            begin
                outer_pat = 8'h38;
                inner_pat = 8'h7c;
            end
            GLYPH_L2:
            begin
                outer_pat = 8'h3c;
                inner_pat = 8'h7e;
            end
            GLYPH_L1:
            begin
                outer_pat = 8'h3c;
                inner_pat = 8'h20;
                red_only  = 1'b1;
            end
            default:
            begin
                outer_pat = '0;   // blank glyphs
                inner_pat = '0;
            end
        endcase
    end

    always_comb
    begin
        case (scan.row_idx)
            3'd1, 3'd4: shape = outer_pat;
            3'd2, 3'd3: shape = inner_pat;
            default:    shape = '0;
        endcase
    end

    // registered so columns line up with the row register
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            colr <= '0;
            colg <= '0;
        end
        else
        begin
            colr <= scan.blank ? '0 : shape;
            colg <= (scan.blank || red_only) ? '0 : shape;
        end
    end

endmodule

// File: src/dz_ctrl.sv
`timescale 1ns/10ps

module dz_ctrl
    import dz_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [GLYPH_W-1:0] num,
    input  logic               blink_en,
    dz_scan_if.control         scan
);

    localparam logic [BLINK_CNT_W-1:0] LAST_BLINK = BLINK_CNT_W'(2 * BLINK_FRAMES - 1);
    localparam logic [BLINK_CNT_W-1:0] BLANK_FROM = BLINK_CNT_W'(BLINK_FRAMES);

    logic                   frame_tick;
    logic [BLINK_CNT_W-1:0] frame_cnt;   // index of the frame about to start

    assign frame_tick = scan.frame_start;   // scanner qualifies it with tick

    // glyph only moves on a frame boundary
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            scan.glyph <= GLYPH_BLANK;
        else if (frame_tick)
            scan.glyph <= num;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            frame_cnt  <= '0;
            scan.blank <= 1'b0;
        end
        else if (frame_tick)
        begin
            if (!blink_en)
            begin
                frame_cnt  <= '0;
                scan.blank <= 1'b0;
            end
            else
            begin
                scan.blank <= (frame_cnt >= BLANK_FROM);   // second half of the cycle
                if (frame_cnt == LAST_BLINK)
                    frame_cnt <= '0;
                else
                    frame_cnt <= frame_cnt + 1'b1;
            end
        end
        else if (!blink_en)
        begin
            frame_cnt <= '0;   // blinking restarts visible
        end
    end

    // frame_start comes from the row scanner and must ride on a tick
    a_glyph_at_frame: assert property (
        @(posedge clk) disable iff (rst) !(scan.tick && scan.frame_start) |=> $stable(scan.glyph)
    ) else $error("glyph changed outside a frame start");

endmodule

// File: src/dz_panel_top.sv
`timescale 1ns/10ps

module dz_panel_top
    import dz_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [GLYPH_W-1:0] num,
    input  logic               blink_en,
    output logic [ROWS-1:0]    row,    // active low
    output logic [COLS-1:0]    colr,
    output logic [COLS-1:0]    colg
);

    logic tick;

    dz_scan_if scan_if ();

    assign scan_if.tick = tick;

    scan_tick_gen u_tick (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    dz_row_scan u_row_scan (
        .clk  (clk),
        .rst  (rst),
        .scan (scan_if.scanner),
        .row  (row)
    );

    dz_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .num      (num),
        .blink_en (blink_en),
        .scan     (scan_if.control)
    );

    dz_glyph_rom u_rom (
        .clk  (clk),
        .rst  (rst),
        .scan (scan_if.store),
        .colr (colr),
        .colg (colg)
    );

endmodule

// File: tb/tb_dz_panel.sv
`timescale 1ns/10ps

module tb_dz_panel
    import dz_pkg::*;
();

    localparam int TIMEOUT = 20 * SCAN_DIV * ROWS;   // clk cycles per wait
    localparam int N_ENTRIES = 16;

    logic               clk;
    logic               rst;
    logic [GLYPH_W-1:0] num;
    logic               blink_en;
    logic [ROWS-1:0]    row;
    logic [COLS-1:0]    colr;
    logic [COLS-1:0]    colg;

    // stimulus table
    logic [GLYPH_W-1:0] tab_num [N_ENTRIES];
    logic               tab_blink [N_ENTRIES];
    int                 tab_frames [N_ENTRIES];

    // model of the frame currently on the panel
    logic [GLYPH_W-1:0] exp_glyph;
    logic               exp_blank;
    int                 blink_cnt;
    int                 prev_idx;
    logic [ROWS-1:0]    prev_row;
    logic               scanning;

    int     errors;
    int     checks;
    logic   timed_out;
    integer seed;

    dz_panel_top dut (
        .clk      (clk),
        .rst      (rst),
        .num      (num),
        .blink_en (blink_en),
        .row      (row),
        .colr     (colr),
        .colg     (colg)
    );

    always #5 clk = ~clk;

    // glyph shapes, rows 1 and 4 outer, rows 2 and 3 inner
    function automatic logic [COLS-1:0] ref_column(input logic [GLYPH_W-1:0] g, input int r,
                                                   input logic green, input logic blanked);
        logic [COLS-1:0] outer;
        logic [COLS-1:0] inner;
        logic [COLS-1:0] pat;
        outer = 8'h00;
        inner = 8'h00;
        case (g)
            3'd4:
            begin
                outer = 8'h18;
                inner = 8'h3c;
            end
            3'd3:
            begin
                outer = 8'h38;
                inner = 8'h7c;
            end
            3'd2:
            begin
                outer = 8'h3c;
                inner = 8'h7e;
            end
            3'd1:
            begin
                outer = 8'h3c;
                inner = 8'h20;
            end
            default:
            begin
                outer = 8'h00;
                inner = 8'h00;
            end
        endcase
        if (r == 1 || r == 4)
            pat = outer;
        else if (r == 2 || r == 3)
            pat = inner;
        else
            pat = 8'h00;
        if (blanked || (green && g == 3'd1))   // glyph 1 has no green
            pat = 8'h00;
        return pat;
    endfunction

    // index of the single low row line, -1 otherwise
    function automatic int low_bit(input logic [ROWS-1:0] r);
        int idx;
        int zeros;
        idx = -1;
        zeros = 0;
        for (int i = 0; i < ROWS; i++)
        begin
            if (!r[i])
            begin
                zeros++;
                idx = i;
            end
        end
        if (zeros != 1)
            idx = -1;
        return idx;
    endfunction

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic set_entry(input int i, input logic [GLYPH_W-1:0] n, input logic b,
                             input int frames);
        tab_num[i] = n;
        tab_blink[i] = b;
        tab_frames[i] = frames;
    endtask

    task automatic fill_table();
        for (int i = 0; i < 8; i++)
            set_entry(i, GLYPH_W'(i), 1'b0, 1);   // every glyph, no blinking
        set_entry(8, 3'd2, 1'b1, 8);    // two lit, two dark, twice over
        set_entry(9, 3'd3, 1'b0, 2);    // blink dropped
        set_entry(10, 3'd4, 1'b1, 5);
        set_entry(11, 3'd1, 1'b0, 2);
        for (int i = 12; i < N_ENTRIES; i++)
            set_entry(i, GLYPH_W'($random(seed)), 1'(i % 2), 3);
    endtask

    // new frame seen on the panel, glyph and blank latched at its start
    task automatic start_frame();
        exp_glyph = num;
        if (!blink_en)
        begin
            blink_cnt = 0;
            exp_blank = 1'b0;
        end
        else
        begin
            exp_blank = (blink_cnt >= BLINK_FRAMES);
            blink_cnt = (blink_cnt + 1) % (2 * BLINK_FRAMES);
        end
    endtask

    // one clock, then every output against the model
    task automatic step_and_check(output int entered);
        int              idx;
        logic [ROWS-1:0] exp_row;
        @(posedge clk);
        #1;
        entered = -1;
        if (row === {ROWS{1'b1}} && !scanning)   // dark until the first row
        begin
            check_value("colr", 8'h00, colr);
            check_value("colg", 8'h00, colg);
        end
        else
        begin
            idx = low_bit(row);
            if (idx < 0)
            begin
                errors++;
                $display("row lines not one-hot active low at t=%0t: %b", $time, row);
            end
            else
            begin
                if (row !== prev_row)
                begin
                    exp_row = ~(ROWS'(1) << ((prev_idx + 1) % ROWS));
                    check_value("row", exp_row, row);
                    if (idx == 0)
                        start_frame();
                    scanning = 1'b1;
                    prev_idx = idx;
                    prev_row = row;
                    entered = idx;
                end
                check_value("colr", ref_column(exp_glyph, idx, 1'b0, exp_blank), colr);
                check_value("colg", ref_column(exp_glyph, idx, 1'b1, exp_blank), colg);
            end
        end
    endtask

    task automatic watch_until_row(input int target);
        int entered;
        int cycles;
        cycles = 0;
        entered = -1;
        while (entered != target && !timed_out)
        begin
            step_and_check(entered);
            cycles++;
            if (cycles >= TIMEOUT && entered != target)
            begin
                timed_out = 1'b1;
                errors++;
                $display("timeout at t=%0t: row %0d never lit", $time, target);
            end
        end
    endtask

    // inputs change part way into a frame, that frame keeps the old glyph
    task automatic run_entry(input int i);
        watch_until_row(3);
        if (!timed_out)
        begin
            num = tab_num[i];
            blink_en = tab_blink[i];
            for (int f = 0; f < tab_frames[i]; f++)
            begin
                if (!timed_out)
                    watch_until_row(0);
            end
        end
    endtask

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        num = '0;
        blink_en = 1'b0;
        errors = 0;
        checks = 0;
        timed_out = 1'b0;
        exp_glyph = '0;
        exp_blank = 1'b0;
        blink_cnt = 0;
        prev_idx = ROWS - 1;
        prev_row = '1;
        scanning = 1'b0;
        seed = 32'h868fccd4;
        fill_table();

        repeat (10)
        begin
            @(posedge clk);
            #1;
            check_value("row", 8'hff, row);
            check_value("colr", 8'h00, colr);
            check_value("colg", 8'h00, colg);
        end
        rst = 1'b0;

        for (int i = 0; i < N_ENTRIES; i++)
        begin
            if (!timed_out)
                run_entry(i);
        end

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: verilog.f
src/dz_pkg.sv
src/dz_scan_if.sv
src/scan_tick_gen.sv
src/dz_row_scan.sv
src/dz_glyph_rom.sv
src/dz_ctrl.sv
src/dz_panel_top.sv
tb/tb_dz_panel.sv

// File: run_sim.sh
#!/bin/sh
# build and run the panel testbench, the log decides pass or fail
rm -rf obj_dir
rm -f build.log sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_dz_panel \
    -o tb_dz_panel > build.log 2>&1 \
    && ./obj_dir/tb_dz_panel > sim.log 2>&1 \
    || echo "build or simulation error, see build.log and sim.log"
grep -q "All tests passed" sim.log 2>/dev/null && echo "PASS" && exit 0 \
    || echo "FAIL" && exit 1
